// ==== div_types_pkg.sv ====
//----------------------------------------
// widths, operand types and message structs
// of the iterative divider, shared by the data blocks
//----------------------------------------

package div_types_pkg;

  // default operand width, the top level passes XLEN down
  localparam int xlen_default = 32;

  // one operand, or one half of the result
  typedef logic [xlen_default-1:0] word_t;

  // working register of the restoring divider
  // guard bit on top, then remainder half, then quotient half
  typedef logic [2*xlen_default:0] dbl_t;

  // wide enough to hold any step index up to xlen_default
  typedef logic [$clog2(xlen_default):0] step_cnt_t;

  // function select carried by the request
  typedef enum logic {
    fn_signed   = 1'b0,
    fn_unsigned = 1'b1
  } div_fn_t;

  // request message, 65 bits
  typedef struct packed {
    div_fn_t fn;
    word_t   a;
    word_t   b;
  } div_req_t;

  // response message, remainder in the upper half
  typedef struct packed {
    word_t rem;
    word_t quo;
  } div_resp_t;

  // sign and special-case flags of the request in flight
  typedef struct packed {
    // quotient needs negation after the unsigned loop
    logic q_neg;
    // remainder takes the sign of the dividend
    logic r_neg;
    // divisor was zero
    logic b_zero;
  } div_flags_t;

endpackage

// ==== div_ctrl_pkg.sv ====
//----------------------------------------
// controller state and control strobes
// shared by the FSM and the datapath
//----------------------------------------

package div_ctrl_pkg;

  // divider FSM states
  // idle waits for a request, calc runs the loop,
  // done holds the response until it is taken
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } div_state_t;

  // strobes from the controller to the datapath
  typedef struct packed {
    // capture operands, fires on the request transfer
    logic load;
    // one restoring step, high in every calc cycle
    logic step;
  } div_ctl_t;

endpackage

// ==== div_ctrl.sv ====
//----------------------------------------
// divider FSM, drives the valid/ready handshake,
// the datapath strobes and the step counter
//----------------------------------------
`timescale 1ns/1ns

module div_ctrl
  import div_ctrl_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_val,
  output logic     req_rdy,
  output logic     resp_val,
  input  logic     resp_rdy,
  output div_ctl_t ctl,
  output logic     cnt_clear,
  output logic     cnt_en,
  input  logic     last_step
);

  div_state_t state;
  div_state_t state_next;

  // handshake transfers in this cycle
  logic req_xfer;
  logic resp_xfer;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  // one division at a time, so only idle accepts
  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  assign req_xfer  = req_val & req_rdy;
  assign resp_xfer = resp_val & resp_rdy;

  // ----------------------------------------
  // state register and next state
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (req_xfer) begin
          state_next = st_calc;
        end
      end
      st_calc: begin
        // counter flags the XLEN-th step
        if (last_step) begin
          state_next = st_done;
        end
      end
      st_done: begin
        // hold result until the consumer takes it
        if (resp_xfer) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // ----------------------------------------
  // strobes
  // ----------------------------------------

  assign ctl = '{load: req_xfer, step: (state == st_calc)};

  // counter runs through calc and is left at zero on exit
  assign cnt_en    = ctl.step;
  assign cnt_clear = req_xfer | (ctl.step & last_step);

  // request and response windows never overlap
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high together");

  // operands are only captured while idle
  a_load_idle: assert property (@(posedge clk) disable iff (reset)
    ctl.load |-> (state == st_idle))
    else $error("load strobe outside idle");

  // calc lasts exactly XLEN cycles, checks the counter handoff too
  a_calc_len: assert property (@(posedge clk) disable iff (reset)
    ctl.load |=> (state == st_calc) [*XLEN] ##1 (state == st_done))
    else $error("calc phase length differs from XLEN");

endmodule

// ==== div_step_counter.sv ====
//----------------------------------------
// step counter of the divide loop,
// flags the last of XLEN steps
//----------------------------------------
`timescale 1ns/1ns

module div_step_counter
  import div_types_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  logic en,
  output logic last_step
);

  // one bit above the step range, a missed clear shows as an overrun
  localparam int CNT_W = $clog2(XLEN) + 1;

  // index of the final step, in the shared count type
  localparam step_cnt_t last_idx = step_cnt_t'(XLEN - 1);

  logic [CNT_W-1:0] count;

  // clear wins over increment
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (en) begin
      count <= count + CNT_W'(1);
    end
  end

  assign last_step = (step_cnt_t'(count) == last_idx);

  // controller clears before the count can run past the last step
  a_cnt_range: assert property (@(posedge clk) disable iff (reset)
    step_cnt_t'(count) <= last_idx)
    else $error("step count beyond XLEN-1");

endmodule

// ==== div_operand_prep.sv ====
//----------------------------------------
// turns the request operands into magnitudes
// and keeps the sign and zero flags of the accepted request
//----------------------------------------
`timescale 1ns/1ns

module div_operand_prep
  import div_types_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic       clk,
  input  logic       reset,
  input  div_req_t   req,
  input  logic       load,
  output word_t      a_mag,
  output word_t      b_mag,
  output div_flags_t flags
);

  logic [XLEN-1:0] a_in;
  logic [XLEN-1:0] b_in;
  logic [XLEN-1:0] a_abs;
  logic [XLEN-1:0] b_abs;
  logic            is_signed;
  logic            a_neg;
  logic            b_neg;

  // operands sit in the low XLEN bits of each field
  assign a_in = req.a[XLEN-1:0];
  assign b_in = req.b[XLEN-1:0];

  // sign bits only count for the signed function
  assign is_signed = (req.fn == fn_signed);
  assign a_neg     = is_signed & a_in[XLEN-1];
  assign b_neg     = is_signed & b_in[XLEN-1];

  // two's complement magnitude
  // most negative value maps onto itself, read as unsigned it is right
  assign a_abs = a_neg ? -a_in : a_in;
  assign b_abs = b_neg ? -b_in : b_in;

  // combinational, the datapath samples these on load
  assign a_mag = word_t'(a_abs);
  assign b_mag = word_t'(b_abs);

  // ----------------------------------------
  // flags of the request in flight
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (load) begin
      // quotient negative when exactly one operand is negative
      flags.q_neg  <= a_neg ^ b_neg;
      // remainder follows the dividend
      flags.r_neg  <= a_neg;
      flags.b_zero <= (b_in == '0);
    end
  end

endmodule

// ==== div_dpath.sv ====
//----------------------------------------
// restoring divider datapath, one quotient bit per step
// working register holds remainder over quotient
//----------------------------------------
`timescale 1ns/1ns

module div_dpath
  import div_types_pkg::*;
  import div_ctrl_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic     clk,
  input  logic     reset,
  input  div_ctl_t ctl,
  input  word_t    a_mag,
  input  word_t    b_mag,
  output dbl_t     work
);

  // guard bit plus two XLEN halves
  localparam int W = 2 * XLEN + 1;

  logic [W-1:0] work_q;
  logic [W-1:0] divisor_q;
  logic [W-1:0] shifted;
  logic [W-1:0] diff;
  logic         diff_neg;

  // ----------------------------------------
  // one restoring step
  // ----------------------------------------

  // shift the partial remainder up by one
  assign shifted = work_q << 1;

  // divisor sits in the remainder half, so low bits pass through
  assign diff     = shifted - divisor_q;
  assign diff_neg = diff[W-1];

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (ctl.load) begin
      // dividend in the low half, remainder half starts at zero
      work_q    <= {{(XLEN + 1){1'b0}}, a_mag[XLEN-1:0]};
      // divisor lined up under the remainder half
      divisor_q <= {1'b0, b_mag[XLEN-1:0], {XLEN{1'b0}}};
    end else if (ctl.step) begin
      if (diff_neg) begin
        // subtract failed, restore and shift in a zero
        work_q <= {shifted[W-1:1], 1'b0};
      end else begin
        // keep difference, quotient bit one
        work_q <= {diff[W-1:1], 1'b1};
      end
    end
  end

  assign work = dbl_t'(work_q);

  // FSM never captures while the loop is running
  a_load_step_excl: assert property (@(posedge clk) disable iff (reset)
    !(ctl.load && ctl.step))
    else $error("load and step strobes together");

endmodule

// ==== div_result_fix.sv ====
//----------------------------------------
// sign correction and divide-by-zero handling,
// packs remainder and quotient into the response
//----------------------------------------
`timescale 1ns/1ns

module div_result_fix
  import div_types_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  dbl_t       work,
  input  div_flags_t flags,
  output div_resp_t  resp
);

  logic [XLEN-1:0] quo_raw;
  logic [XLEN-1:0] rem_raw;
  logic [XLEN-1:0] quo_fix;
  logic [XLEN-1:0] rem_fix;

  // unsigned results of the loop
  assign quo_raw = work[XLEN-1:0];
  assign rem_raw = work[2*XLEN-1:XLEN];

  always_comb begin
    quo_fix = flags.q_neg ? -quo_raw : quo_raw;
    // zero divisor gives all ones whatever the signs
    if (flags.b_zero) begin
      quo_fix = '1;
    end
    // with a zero divisor the loop leaves the dividend magnitude here,
    // so the sign fix hands back the dividend itself
    rem_fix = flags.r_neg ? -rem_raw : rem_raw;
  end

  // most negative over minus one needs no case of its own,
  // the magnitude 2^(XLEN-1) already reads back as the most negative value

  // remainder upper, quotient lower
  assign resp.rem = word_t'(rem_fix);
  assign resp.quo = word_t'(quo_fix);

endmodule

// ==== int_div_iterative.sv ====
//----------------------------------------
// iterative integer divider, top level
// valid/ready request in, one response out per division
//----------------------------------------
`timescale 1ns/1ns

module int_div_iterative
  import div_types_pkg::*;
  import div_ctrl_pkg::*;
#(
  parameter int XLEN = xlen_default
) (
  input  logic      clk,
  input  logic      reset,
  input  div_req_t  req,
  input  logic      req_val,
  output logic      req_rdy,
  output div_resp_t resp,
  output logic      resp_val,
  input  logic      resp_rdy
);

  // controller to datapath and counter
  div_ctl_t   ctl;
  logic       cnt_clear;
  logic       cnt_en;
  logic       last_step;

  // data between the blocks
  word_t      a_mag;
  word_t      b_mag;
  div_flags_t flags;
  dbl_t       work;

  // ----------------------------------------
  // control
  // ----------------------------------------

  div_ctrl #(.XLEN(XLEN)) i_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .ctl       (ctl),
    .cnt_clear (cnt_clear),
    .cnt_en    (cnt_en),
    .last_step (last_step)
  );

  div_step_counter #(.XLEN(XLEN)) i_cnt (
    .clk       (clk),
    .reset     (reset),
    .clear     (cnt_clear),
    .en        (cnt_en),
    .last_step (last_step)
  );

  // ----------------------------------------
  // data
  // ----------------------------------------

  div_operand_prep #(.XLEN(XLEN)) i_prep (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .load  (ctl.load),
    .a_mag (a_mag),
    .b_mag (b_mag),
    .flags (flags)
  );

  div_dpath #(.XLEN(XLEN)) i_dpath (
    .clk   (clk),
    .reset (reset),
    .ctl   (ctl),
    .a_mag (a_mag),
    .b_mag (b_mag),
    .work  (work)
  );

  div_result_fix #(.XLEN(XLEN)) i_fix (
    .work  (work),
    .flags (flags),
    .resp  (resp)
  );

endmodule

// ==== tb_int_div_iterative.sv ====
//----------------------------------------
// testbench of the iterative divider, directed and random
// divisions checked against a reference model of the rules
//----------------------------------------
`timescale 1ns/1ns

module tb_int_div_iterative
  import div_types_pkg::*;
();

  localparam int XLEN = 32;
  // generous bound on any single wait, a division takes XLEN+1 cycles
  localparam int WAIT_LIMIT = 4 * XLEN;
  localparam int N_RANDOM = 200;

  logic      clk;
  logic      reset;
  div_req_t  req;
  logic      req_val;
  logic      req_rdy;
  div_resp_t resp;
  logic      resp_val;
  logic      resp_rdy;

  int        seed;
  int        errors;
  int        mon_errors;
  int        tests;
  int        err_start;
  int        req_count;
  int        resp_count;
  bit        aborted;
  string     cur_test;
  // expected responses in request order, one division in flight at most
  div_resp_t exp_q[$];
  string     name_q[$];

  int_div_iterative #(.XLEN(XLEN)) i_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #5 clk = ~clk;

  // ----------------------------------------
  // reference model and checking
  // ----------------------------------------

  function automatic div_resp_t div_model(div_fn_t fn, word_t a, word_t b);
    div_resp_t r;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = $signed(a);
    sb = $signed(b);
    if (b == '0) begin
      // divide by zero, all ones over the dividend
      r.quo = '1;
      r.rem = a;
    end else if (fn == fn_unsigned) begin
      r.quo = a / b;
      r.rem = a % b;
    end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      // signed overflow keeps the most negative value
      r.quo = a;
      r.rem = '0;
    end else begin
      // truncating division, remainder takes the dividend sign
      r.quo = sa / sb;
      r.rem = sa % sb;
    end
    return r;
  endfunction

  task automatic check_eq(string name, logic [63:0] expected, logic [63:0] actual,
                          inout int errs);
    if (expected !== actual) begin
      errs++;
      $display("ERROR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // watches both handshakes mid-cycle, where every signal has settled
  // queues the model result on each request
  always @(negedge clk) begin
    if (!reset) begin
      if (req_val && req_rdy) begin
        exp_q.push_back(div_model(req.fn, req.a, req.b));
        name_q.push_back(cur_test);
        req_count++;
      end
      if (resp_val && resp_rdy) begin
        resp_count++;
        if (exp_q.size() == 0) begin
          mon_errors++;
          $display("test %s got a response with no request outstanding", cur_test);
        end else begin
          check_eq(name_q.pop_front(), exp_q.pop_front(), resp, mon_errors);
        end
      end
    end
  end

  // ----------------------------------------
  // handshake helpers
  // ----------------------------------------

  task automatic report_timeout(string what);
    errors++;
    aborted = 1'b1;
    $display("test %s timed out waiting for %s", cur_test, what);
  endtask

  task automatic send_req(div_fn_t fn, word_t a, word_t b);
    int  n;
    bit  done;
    if (aborted) return;
    req.fn  = fn;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    n = 0;
    done = 1'b0;
    // req_rdy high 1 ns after an edge makes the next edge the transfer
    while (!done && n < WAIT_LIMIT) begin
      done = req_rdy;
      @(posedge clk);
      #1;
      n++;
    end
    req_val = 1'b0;
    if (!done) report_timeout("the request to be accepted");
  endtask

  // counts cycles from the request transfer cycle to the first resp_val cycle
  task automatic wait_resp_val(output int n);
    bit done;
    n = 1;
    done = 1'b0;
    if (aborted) return;
    done = resp_val;
    while (!done && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
      done = resp_val;
    end
    if (!done) report_timeout("resp_val");
  endtask

  task automatic wait_resp_xfer();
    int n;
    bit done;
    if (aborted) return;
    n = 0;
    done = 1'b0;
    // valid and ready seen 1 ns after an edge transfer on the next edge
    while (!done && n < WAIT_LIMIT) begin
      done = resp_val && resp_rdy;
      @(posedge clk);
      #1;
      n++;
    end
    if (!done) report_timeout("the response transfer");
  endtask

  task automatic run_div(div_fn_t fn, word_t a, word_t b);
    send_req(fn, a, b);
    wait_resp_xfer();
  endtask

  // small divisors are common, the right shift makes them likely
  task automatic random_req(output div_fn_t fn, output word_t a, output word_t b);
    fn = (($random(seed) & 1) != 0) ? fn_unsigned : fn_signed;
    a = $random(seed);
    b = $random(seed);
    b = b >> ($random(seed) & 31);
  endtask

  task automatic start_test(string name);
    cur_test = name;
    err_start = errors + mon_errors;
    tests++;
  endtask

  task automatic finish_test();
    int errs;
    errs = errors + mon_errors - err_start;
    $display("test %-14s %s, %0d errors", cur_test, (errs == 0) ? "ok" : "bad", errs);
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic test_directed();
    word_t mag_a [3];
    word_t mag_b [3];
    word_t a;
    word_t b;
    start_test("directed");
    mag_a = '{32'd100, 32'd5, 32'h7fff_ffff};
    mag_b = '{32'd7, 32'd9, 32'd3};
    for (int j = 0; j < 3; j++) begin
      // all four sign combinations, both functions
      for (int i = 0; i < 4; i++) begin
        a = i[0] ? -mag_a[j] : mag_a[j];
        b = i[1] ? -mag_b[j] : mag_b[j];
        run_div(fn_signed, a, b);
        run_div(fn_unsigned, a, b);
      end
    end
    finish_test();
  endtask

  task automatic test_special();
    start_test("special");
    run_div(fn_signed, 32'd1234, 32'd0);
    run_div(fn_signed, 32'hffff_fb2e, 32'd0);
    run_div(fn_unsigned, 32'hdead_beef, 32'd0);
    run_div(fn_signed, 32'h8000_0000, 32'hffff_ffff);
    run_div(fn_unsigned, 32'h8000_0000, 32'hffff_ffff);
    run_div(fn_signed, 32'h8000_0000, 32'd1);
    finish_test();
  endtask

  task automatic test_latency();
    int n;
    start_test("latency");
    check_eq(cur_test, 64'(1), 64'(req_rdy), errors);
    check_eq(cur_test, 64'(0), 64'(resp_val), errors);
    // hold the response back so its first cycle can be counted
    resp_rdy = 1'b0;
    send_req(fn_unsigned, 32'd1000, 32'd3);
    wait_resp_val(n);
    if (!aborted) check_eq(cur_test, 64'(XLEN + 1), 64'(n), errors);
    resp_rdy = 1'b1;
    wait_resp_xfer();
    finish_test();
  endtask

  task automatic test_backpressure();
    div_fn_t   fn;
    word_t     a;
    word_t     b;
    div_resp_t expected;
    int        n;
    int        stall;
    start_test("backpressure");
    resp_rdy = 1'b0;
    for (int i = 0; i < 8; i++) begin
      random_req(fn, a, b);
      expected = div_model(fn, a, b);
      send_req(fn, a, b);
      wait_resp_val(n);
      stall = 1 + ($random(seed) & 15);
      // response held and valid, no new request taken meanwhile
      for (int k = 0; k < stall && !aborted; k++) begin
        @(posedge clk);
        #1;
        check_eq(cur_test, expected, resp, errors);
        check_eq(cur_test, 64'(1), 64'(resp_val), errors);
        check_eq(cur_test, 64'(0), 64'(req_rdy), errors);
      end
      resp_rdy = 1'b1;
      wait_resp_xfer();
      resp_rdy = 1'b0;
    end
    resp_rdy = 1'b1;
    finish_test();
  endtask

  task automatic test_random();
    div_fn_t fn;
    word_t   a;
    word_t   b;
    int      gap;
    start_test("random");
    for (int i = 0; i < N_RANDOM; i++) begin
      random_req(fn, a, b);
      gap = $random(seed) & 7;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      run_div(fn, a, b);
    end
    check_eq(cur_test, 64'(req_count), 64'(resp_count), errors);
    finish_test();
  endtask

  initial begin
    seed       = 32'hd02f;
    clk        = 1'b0;
    reset      = 1'b1;
    req        = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b1;
    errors     = 0;
    mon_errors = 0;
    tests      = 0;
    req_count  = 0;
    resp_count = 0;
    aborted    = 1'b0;
    cur_test   = "reset";
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    test_latency();
    test_directed();
    test_special();
    test_backpressure();
    test_random();
    $display("tests %0d, requests %0d, responses %0d, errors %0d",
             tests, req_count, resp_count, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
div_types_pkg.sv
div_ctrl_pkg.sv
div_ctrl.sv
div_step_counter.sv
div_operand_prep.sv
div_dpath.sv
div_result_fix.sv
int_div_iterative.sv
tb_int_div_iterative.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the divider testbench with Verilator and runs it
# exit status is zero only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

top=tb_int_div_iterative
log=sim.log

verilator --binary --timing --assert -f project.f --top-module "$top" \
  --Mdir obj_dir -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
